// File: verilog/fetch_macros.svh
// Fetch front end parameters
// Word and PC width, the PC taken after reset and the width of the
// jump tag that travels with each instruction to decode

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ====================
// Datapath
// ====================

`define FETCH_XLEN      32              // PC and memory word width
`define FETCH_RESET_PC  32'h0000_0000   // First fetch address after reset

// ====================
// Jump tracking
// ====================

`define FETCH_TAG_W     3               // Jump tag counter width

`endif

// File: verilog/fetch_pkg.sv
// Fetch front end types
// Shared word view and the structs passed between the fetch stage,
// the prefetch-aligner and the compressed instruction expander

`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // One memory word, read either whole or as two 16-bit parcels
    typedef union packed {
        logic [`FETCH_XLEN-1:0] word;           // Full 32-bit instruction view
        struct packed {
            logic [`FETCH_XLEN/2-1:0] upper;    // Parcel at address + 2
            logic [`FETCH_XLEN/2-1:0] lower;    // Parcel at address + 0
        } parcel;
    } fetch_word_u;

    // Fetch stage to aligner
    typedef struct packed {
        logic                    jump;              // Jump waiting for the aligner
        logic [`FETCH_XLEN-1:0]  target;            // Word address of the target
        logic                    jump_misaligned;   // Target sits on the upper parcel
        logic [`FETCH_TAG_W-1:0] tag;               // Current jump tag
    } fetch_req_t;

    // Aligner to expander
    typedef struct packed {
        logic [`FETCH_XLEN-1:0]  pc;
        fetch_word_u             instr;             // Raw, possibly compressed
        logic                    compressed;
        logic [`FETCH_TAG_W-1:0] tag;
    } aligned_instr_t;

    // Front end to decode
    typedef struct packed {
        logic [`FETCH_XLEN-1:0]  pc;
        logic [`FETCH_XLEN-1:0]  instr;             // Always the 32-bit form
        logic                    compressed;
        logic                    illegal;           // Unsupported compressed code
        logic [`FETCH_TAG_W-1:0] tag;
    } decoded_instr_t;

endpackage

`default_nettype wire

// File: verilog/fetch_pc_gen.sv
// Fetch stage
// Issues word addresses to the synchronous instruction memory, follows
// jumps to any halfword target and counts the jump tag. A jump stays
// posted to the aligner until the aligner takes it on an advance cycle

`default_nettype none

`include "fetch_macros.svh"

module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   hazard_i,
    input  logic                   jump_i,
    input  logic [`FETCH_XLEN-1:0] jump_pc_i,
    input  logic                   prefetched_i,
    output logic [`FETCH_XLEN-1:0] mem_addr_o,
    output fetch_pkg::fetch_req_t  req_o
);
    import fetch_pkg::*;

    localparam logic [`FETCH_XLEN-1:0] WORD_STEP = 4;

    logic                   advance;
    logic                   jump_taken;
    logic [`FETCH_XLEN-1:0] jump_word;
    logic [`FETCH_XLEN-1:0] rd_addr_r;      // Address of the word now on the read port
    fetch_req_t             req_r;

    assign advance    = enable_i && !hazard_i;
    assign jump_taken = enable_i && jump_i;      // Jumps are taken even under hazard
    assign jump_word  = {jump_pc_i[`FETCH_XLEN-1:2], 2'b00};

    // ====================
    // Address select
    // ====================

    // Re-reading the current word keeps the read port in step with the aligner
    // whenever it does not consume that word
    always_comb begin
        if (jump_taken) begin
            mem_addr_o = jump_word;
        end else if (advance && !prefetched_i) begin
            mem_addr_o = rd_addr_r + WORD_STEP;
        end else begin
            mem_addr_o = rd_addr_r;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr_r <= `FETCH_RESET_PC;
        end else begin
            rd_addr_r <= mem_addr_o;
        end
    end

    // ====================
    // Jump request and tag
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_r.jump            <= 1'b0;
            req_r.target          <= `FETCH_RESET_PC;
            req_r.jump_misaligned <= 1'b0;
            req_r.tag             <= '0;
        end else if (jump_taken) begin
            req_r.jump            <= 1'b1;
            req_r.target          <= jump_word;
            req_r.jump_misaligned <= jump_pc_i[1];      // Halfword target needs a filler cycle
            req_r.tag             <= req_r.tag + 1'b1;
        end else if (advance) begin
            req_r.jump            <= 1'b0;              // Aligner took the jump this cycle
            req_r.jump_misaligned <= 1'b0;
        end
    end

    assign req_o = req_r;

endmodule

`default_nettype wire

// File: verilog/iprefetch.sv
// Prefetch-aligner stage
// Rebuilds 16- and 32-bit instructions that start on any halfword of the
// fetched word stream. The previous word is kept so that an instruction
// crossing a word boundary can be spliced, and so that a compressed
// instruction held in its upper parcel is served without a new fetch

`default_nettype none

`include "fetch_macros.svh"

module iprefetch (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enable_i,
    input  logic                      hazard_i,
    input  fetch_pkg::fetch_req_t     req_i,
    input  fetch_pkg::fetch_word_u    mem_rdata_i,
    output logic                      prefetched_o,
    output fetch_pkg::aligned_instr_t instr_o
);
    import fetch_pkg::*;

    localparam logic [`FETCH_XLEN-1:0] HALF_STEP = 2;
    localparam logic [`FETCH_XLEN-1:0] WORD_STEP = 4;

    logic                   advance;
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] pc_r;
    logic [`FETCH_XLEN-1:0] next_pc;
    logic                   misaligned;
    logic                   misaligned_r;
    logic                   prefetched;
    logic                   prefetched_r;
    logic                   compressed;
    fetch_word_u            word_r;          // Previous fetch word
    fetch_word_u            word_spliced;
    fetch_word_u            word_sel;
    aligned_instr_t         instr_r;

    assign advance = enable_i && !hazard_i;

    // ====================
    // PC control
    // ====================

    // A posted jump overrides the running PC until the aligner advances on it
    assign pc         = req_i.jump ? req_i.target : pc_r;
    assign misaligned = pc[1];

    // The filler cycle of a halfword jump only steps onto the upper parcel
    assign next_pc = pc + ((compressed || req_i.jump_misaligned) ? HALF_STEP : WORD_STEP);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_r         <= `FETCH_RESET_PC;
            misaligned_r <= 1'b0;
            prefetched_r <= 1'b0;
        end else if (advance) begin
            pc_r         <= next_pc;
            misaligned_r <= misaligned;
            prefetched_r <= prefetched;
        end
    end

    // ====================
    // Word alignment
    // ====================

    always_comb begin
        word_spliced.parcel.lower = word_r.parcel.upper;        // Start of the instruction
        word_spliced.parcel.upper = mem_rdata_i.parcel.lower;   // Rest from the new word

        if (misaligned) begin
            word_sel = word_spliced;
        end else if (misaligned_r && !req_i.jump) begin
            word_sel = word_r;                  // Word already held after a prefetched parcel
        end else begin
            word_sel = mem_rdata_i;
        end
    end

    // Low two bits of 11 mark a 32-bit instruction
    assign compressed = (word_sel.parcel.lower[1:0] != 2'b11);

    // Compressed instruction found wholly in the stored upper parcel
    assign prefetched   = misaligned && compressed;
    assign prefetched_o = prefetched;

    always_ff @(posedge clk) begin
        if (advance && (req_i.jump || !(prefetched_r && compressed))) begin
            word_r <= mem_rdata_i;
        end
    end

    // ====================
    // Output register
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_r.pc         <= `FETCH_RESET_PC;
            instr_r.instr      <= '0;
            instr_r.compressed <= 1'b0;
            instr_r.tag        <= '1;           // Never equal to the first live tag
        end else if (advance) begin
            instr_r.pc         <= pc;
            instr_r.instr      <= word_sel;
            instr_r.compressed <= compressed;
            // The filler entry keeps the old tag so the expander drops it
            if (!req_i.jump_misaligned) begin
                instr_r.tag <= req_i.tag;
            end
        end
    end

    assign instr_o = instr_r;

endmodule

`default_nettype wire

// File: verilog/rvc_expander.sv
// Compressed instruction expander
// Rewrites the supported RVC subset into the equivalent 32-bit encoding,
// flags other compressed codes as illegal and registers the result for
// decode. Entries carrying a stale jump tag never raise valid

`default_nettype none

`include "fetch_macros.svh"

module rvc_expander (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enable_i,
    input  logic                      hazard_i,
    input  logic [`FETCH_TAG_W-1:0]   current_tag_i,
    input  fetch_pkg::aligned_instr_t instr_i,
    output fetch_pkg::decoded_instr_t decoded_o,
    output logic                      valid_o
);
    import fetch_pkg::*;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic                     advance;
    logic [`FETCH_XLEN/2-1:0] parcel;
    logic [4:0]               rd;
    logic [4:0]               rs2;
    logic [`FETCH_XLEN-1:0]   expanded;
    logic                     illegal;
    decoded_instr_t           decoded_r;
    logic                     issued_r;     // decoded_r was loaded last cycle

    assign advance = enable_i && !hazard_i;
    assign parcel  = instr_i.instr.parcel.lower;
    assign rd      = parcel[11:7];
    assign rs2     = parcel[6:2];

    // ====================
    // Expansion table
    // ====================

    // Cases are selected by quadrant and funct3
    always_comb begin
        expanded = '0;
        illegal  = 1'b0;

        if (!instr_i.compressed) begin
            expanded = instr_i.instr.word;
        end else begin
            illegal = 1'b1;                         // Cleared by a supported code
            case ({parcel[1:0], parcel[15:13]})
                5'b01_000: begin                    // C.ADDI and C.NOP
                    expanded = {{6{parcel[12]}}, parcel[12], parcel[6:2],
                                rd, 3'b000, rd, OPC_OP_IMM};
                    illegal  = 1'b0;
                end
                5'b01_010: begin                    // C.LI
                    expanded = {{6{parcel[12]}}, parcel[12], parcel[6:2],
                                5'd0, 3'b000, rd, OPC_OP_IMM};
                    illegal  = 1'b0;
                end
                5'b01_011: begin
                    if (rd != 5'd2) begin           // x2 here would be C.ADDI16SP
                        expanded = {{14{parcel[12]}}, parcel[12], parcel[6:2], rd, OPC_LUI};
                        illegal  = 1'b0;
                    end
                end
                5'b01_101: begin                    // C.J as JAL x0
                    expanded = {parcel[12], parcel[8], parcel[10:9], parcel[6], parcel[7],
                                parcel[2], parcel[11], parcel[5:3], parcel[12],
                                {8{parcel[12]}}, 5'd0, OPC_JAL};
                    illegal  = 1'b0;
                end
                5'b10_010: begin
                    if (rd != 5'd0) begin           // C.LWSP
                        expanded = {4'b0000, parcel[3:2], parcel[12], parcel[6:4], 2'b00,
                                    5'd2, 3'b010, rd, OPC_LOAD};
                        illegal  = 1'b0;
                    end
                end
                5'b10_100: begin
                    // A zero rs2 would be C.JR, C.JALR or C.EBREAK
                    if (rs2 != 5'd0) begin
                        if (parcel[12]) begin       // C.ADD
                            expanded = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
                        end else begin              // C.MV
                            expanded = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};
                        end
                        illegal = 1'b0;
                    end
                end
                5'b10_110: begin                    // C.SWSP
                    expanded = {4'b0000, parcel[8:7], parcel[12], rs2, 5'd2, 3'b010,
                                parcel[11:9], 2'b00, OPC_STORE};
                    illegal  = 1'b0;
                end
                default: begin
                    expanded = '0;
                end
            endcase
        end
    end

    // ====================
    // Decode register
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            decoded_r <= '0;
            issued_r  <= 1'b0;
        end else begin
            issued_r <= advance;
            if (advance) begin
                decoded_r.pc         <= instr_i.pc;
                decoded_r.instr      <= expanded;
                decoded_r.compressed <= instr_i.compressed;
                decoded_r.illegal    <= illegal;
                decoded_r.tag        <= instr_i.tag;
            end
        end
    end

    assign decoded_o = decoded_r;

    // A taken jump moves the tag at the next edge, so older entries drop out from then on
    assign valid_o = issued_r && (decoded_r.tag == current_tag_i);

endmodule

`default_nettype wire

// File: verilog/fetch_frontend.sv
// Instruction fetch front end
// Chains the fetch stage, the prefetch-aligner and the RVC expander
// between the synchronous instruction memory and decode

`default_nettype none

`include "fetch_macros.svh"

module fetch_frontend (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      enable_i,
    input  logic                      hazard_i,
    input  logic                      jump_i,
    input  logic [`FETCH_XLEN-1:0]    jump_pc_i,
    input  logic [`FETCH_XLEN-1:0]    mem_rdata_i,
    output logic [`FETCH_XLEN-1:0]    mem_addr_o,
    output fetch_pkg::decoded_instr_t decoded_o,
    output logic                      valid_o
);
    import fetch_pkg::*;

    fetch_req_t     fetch_req;
    fetch_word_u    mem_word;
    aligned_instr_t aligned_instr;
    logic           prefetched;

    assign mem_word.word = mem_rdata_i;

    fetch_pc_gen i_fetch_pc_gen (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_i),
        .hazard_i     (hazard_i),
        .jump_i       (jump_i),
        .jump_pc_i    (jump_pc_i),
        .prefetched_i (prefetched),
        .mem_addr_o   (mem_addr_o),
        .req_o        (fetch_req)
    );

    iprefetch i_iprefetch (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_i),
        .hazard_i     (hazard_i),
        .req_i        (fetch_req),
        .mem_rdata_i  (mem_word),
        .prefetched_o (prefetched),
        .instr_o      (aligned_instr)
    );

    rvc_expander i_rvc_expander (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .hazard_i      (hazard_i),
        .current_tag_i (fetch_req.tag),       // Live tag from the fetch stage
        .instr_i       (aligned_instr),
        .decoded_o     (decoded_o),
        .valid_o       (valid_o)
    );

endmodule

`default_nettype wire

// File: verification/fetch_model.svh
// Reference model of the fetch front end
// Walks the program image from the model PC, takes the instruction
// length from the low two bits of each parcel and expands the supported
// RVC subset into its 32-bit form. Predictions queue up in program order

`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// Parcel at any halfword of the image
function automatic logic [15:0] half_at(input logic [`FETCH_XLEN-1:0] addr);
    logic [`FETCH_XLEN-1:0] w;
    w = mem[addr[MEM_AW+1:2]];
    return addr[1] ? w[31:16] : w[15:0];
endfunction

function automatic decoded_instr_t predict(input logic [`FETCH_XLEN-1:0] pc);
    decoded_instr_t d;
    logic [15:0]    p;
    logic [4:0]     rd;
    logic [4:0]     rs2;
    logic [11:0]    imm;                // CI immediate, sign extended
    logic [20:0]    joff;               // C.J byte offset, sign extended
    logic [7:0]     ldoff;
    logic [7:0]     stoff;

    p     = half_at(pc);
    rd    = p[11:7];
    rs2   = p[6:2];
    imm   = {{6{p[12]}}, p[12], p[6:2]};
    joff  = {{9{p[12]}}, p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
    ldoff = {p[3:2], p[12], p[6:4], 2'b00};
    stoff = {p[8:7], p[12:9], 2'b00};

    d            = '0;
    d.pc         = pc;
    d.tag        = model_tag;
    d.compressed = (p[1:0] != 2'b11);
    if (!d.compressed) begin
        d.instr = {half_at(pc + 2), p};
    end else begin
        case ({p[1:0], p[15:13]})
            5'b01_000: d.instr = {imm, rd, 3'b000, rd, 7'h13};              // C.ADDI, C.NOP
            5'b01_010: d.instr = {imm, 5'd0, 3'b000, rd, 7'h13};            // C.LI
            5'b01_011: d.instr = (rd != 5'd2) ? {{8{imm[11]}}, imm, rd, 7'h37} : '0;
            5'b01_101: d.instr = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'h6f};
            5'b10_010: d.instr = (rd != 5'd0) ? {4'b0, ldoff, 5'd2, 3'b010, rd, 7'h03} : '0;
            5'b10_100: d.instr = (rs2 == 5'd0) ? '0 :
                                 {7'b0, rs2, p[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
            5'b10_110: d.instr = {4'b0, stoff[7:5], rs2, 5'd2, 3'b010, stoff[4:0], 7'h23};
            default:   d.instr = '0;
        endcase
        // Every supported form has a nonzero opcode
        d.illegal = (d.instr == '0);
    end
    return d;
endfunction

task automatic model_fill(input int count);
    decoded_instr_t d;
    repeat (count) begin
        d = predict(model_pc);
        exp_q.push_back(d);
        model_pc = model_pc + (d.compressed ? 2 : 4);
    end
endtask

// A jump drops all pending predictions and opens a new tag
task automatic model_restart(input logic [`FETCH_XLEN-1:0] target);
    exp_q.delete();
    model_pc  = target;
    model_tag = model_tag + 1'b1;
endtask

`endif

// File: verification/fetch_frontend_tb.sv
// Testbench for the instruction fetch front end
// Runs a random mixed RV32IC program out of a synchronous memory model
// under random enable, hazard and jump stimulus, and checks every valid
// decoded instruction against the reference model

`default_nettype none

`include "fetch_macros.svh"

module fetch_frontend_tb;
    import fetch_pkg::*;

    localparam int MEM_AW     = 8;
    localparam int MEM_WORDS  = 1 << MEM_AW;
    localparam int NUM_CHECKS = 600;
    localparam int MAX_CYCLES = 5000;
    localparam int DRY_LIMIT  = 12;              // Advance cycles allowed without output

    logic                    clk;
    logic                    reset_n;
    logic                    enable_i;
    logic                    hazard_i;
    logic                    jump_i;
    logic [`FETCH_XLEN-1:0]  jump_pc_i;
    logic [`FETCH_XLEN-1:0]  mem_rdata_i;
    logic [`FETCH_XLEN-1:0]  mem_addr_o;
    decoded_instr_t          decoded_o;
    logic                    valid_o;

    logic [`FETCH_XLEN-1:0]  mem [0:MEM_WORDS-1];
    decoded_instr_t          exp_q[$];
    logic [`FETCH_XLEN-1:0]  model_pc;
    logic [`FETCH_TAG_W-1:0] model_tag;
    int                      errors;
    int                      checked;

    `include "fetch_model.svh"

    fetch_frontend i_fetch_frontend (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable_i),
        .hazard_i    (hazard_i),
        .jump_i      (jump_i),
        .jump_pc_i   (jump_pc_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_addr_o  (mem_addr_o),
        .decoded_o   (decoded_o),
        .valid_o     (valid_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        mem_rdata_i <= mem[mem_addr_o[MEM_AW+1:2]];     // One cycle read latency
    end

    // ====================
    // Stimulus and checks
    // ====================

    function automatic logic [15:0] gen_parcel();
        logic [15:0] p;
        int          q;
        p = $urandom;
        q = $urandom_range(0, 2);
        case ($urandom_range(0, 12))
            0, 1, 2, 3: p[1:0] = 2'b11;                 // Low half of a 32-bit instruction
            4:  {p[1:0], p[15:13]} = 5'b01_000;
            5:  {p[1:0], p[15:13]} = 5'b01_010;
            6:  {p[1:0], p[15:13]} = 5'b01_011;
            7:  {p[1:0], p[15:13]} = 5'b01_101;
            8:  {p[1:0], p[15:13]} = 5'b10_010;
            9:  {p[1:0], p[15:13]} = 5'b10_100;
            10: {p[1:0], p[15:13]} = 5'b10_110;
            11: p = 16'h0001;                           // C.NOP
            default: p[1:0] = q[1:0];                   // Mostly outside the subset
        endcase
        return p;
    endfunction

    function automatic string format_decoded(input decoded_instr_t d);
        return $sformatf("pc %h instr %h c %b ill %b tag %0d",
                         d.pc, d.instr, d.compressed, d.illegal, d.tag);
    endfunction

    task automatic check_decoded(input string name, input decoded_instr_t exp,
                                 input decoded_instr_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %s, actual %s", name,
                     format_decoded(exp), format_decoded(act));
        end
    endtask

    task automatic check_addr(input string name, input logic [`FETCH_XLEN-1:0] exp,
                              input logic [`FETCH_XLEN-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    initial begin
        int                     i;
        int                     cycle;
        int                     dry;
        logic                   was_advance;
        decoded_instr_t         head;
        decoded_instr_t         last_dec;
        logic [`FETCH_XLEN-1:0] last_addr;

        void'($urandom(13870));
        errors      = 0;
        checked     = 0;
        reset_n     = 1'b0;
        enable_i    = 1'b0;
        hazard_i    = 1'b0;
        jump_i      = 1'b0;
        jump_pc_i   = '0;
        mem_rdata_i = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {gen_parcel(), gen_parcel()};
        end
        model_pc  = `FETCH_RESET_PC;
        model_tag = '0;

        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_flag("reset valid", 1'b0, valid_o);
            check_addr("reset addr", `FETCH_RESET_PC, mem_addr_o);
            check_decoded("reset decoded", '0, decoded_o);
        end
        last_dec    = decoded_o;
        last_addr   = mem_addr_o;
        was_advance = 1'b0;
        dry         = 0;
        cycle       = 0;

        while (checked < NUM_CHECKS && cycle < MAX_CYCLES && dry <= DRY_LIMIT) begin
            @(negedge clk);
            cycle++;
            // A frozen cycle keeps decode output and issues nothing
            if (!was_advance) begin
                check_decoded("hold", last_dec, decoded_o);
                check_flag("hold valid", 1'b0, valid_o);
            end
            if (valid_o) begin
                if (exp_q.size() == 0) begin
                    model_fill(8);
                end
                head = exp_q.pop_front();
                check_decoded("stream", head, decoded_o);
                checked++;
                dry = 0;
            end
            last_dec = decoded_o;

            enable_i  = ($urandom_range(0, 9) != 0);
            hazard_i  = ($urandom_range(0, 5) == 0);
            jump_i    = enable_i && ($urandom_range(0, 19) == 0);
            jump_pc_i = $urandom_range(0, 2 * MEM_WORDS - 1) << 1;  // Any halfword
            if (jump_i) begin
                model_restart(jump_pc_i);
                dry = 0;
            end
            was_advance = enable_i && !hazard_i;
            if (was_advance) begin
                dry++;
            end

            #1;
            if (jump_i) begin
                check_addr("jump addr", (jump_pc_i >> 2) << 2, mem_addr_o);
            end else if (!was_advance) begin
                check_addr("stall addr", last_addr, mem_addr_o);
            end
            last_addr = mem_addr_o;
        end

        if (checked < NUM_CHECKS) begin
            errors++;
            $display("Front end stopped delivering instructions after %0d of %0d",
                     checked, NUM_CHECKS);
        end
        $display("Errors: %0d, instructions checked: %0d", errors, checked);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verilog
+incdir+verification
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/iprefetch.sv
verilog/rvc_expander.sv
verilog/fetch_frontend.sv
verification/fetch_frontend_tb.sv
